// ==== verilog.f ====
logic/rv_pkg.sv
logic/control_unit.sv
logic/imm_decode.sv
logic/register_file.sv
logic/alu.sv
logic/pc_unit.sv
logic/cpu.sv
tb/cpu_checker.sv
tb/tb_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile the rv32i core and its testbench with verilator, run it,
# then look for the pass line in the simulation log

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_cpu -Mdir obj_dir -o sim_cpu > build.log 2>&1 &&
./obj_dir/sim_cpu > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -qx "Test passed" sim.log &&
{ echo "PASS"; exit 0; } ||
{ echo "FAIL, see sim.log"; exit 1; }

// ==== tb/tb_cpu.sv ====
// ------------------
// rv32i core testbench
// reset, random instruction classes,
// test sequencing and watchdog
// ------------------
`timescale 1ns/100ps
`default_nettype none

module tb_cpu import rv_pkg::*; ();

    localparam int NUM_TESTS       = 6;
    localparam int INSTRS_PER_TEST = 200;
    localparam int CLK_PERIOD      = 4;
    // two cycles per instruction covers the idle cycles, margin for reset and drain
    localparam int TIMEOUT_NS = NUM_TESTS * INSTRS_PER_TEST * 2 * CLK_PERIOD + 200;

    logic  clk;
    logic  rst;
    word_t cmd;
    logic  cmd_valid;
    word_t pc;
    word_t dnpc;
    wb_t   wb;
    logic  illegal;
    int    errors;
    int    checks;
    int    seed;
    int    errs_before;

    cpu DUT (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .pc        (pc),
        .dnpc      (dnpc),
        .wb        (wb),
        .illegal   (illegal)
    );

    cpu_checker u_checker (
        .clk (clk), .rst (rst), .cmd (cmd), .cmd_valid (cmd_valid),
        .pc (pc), .dnpc (dnpc), .wb (wb), .illegal (illegal),
        .errors (errors), .checks (checks)
    );

    function automatic string test_name(input int t);
        case (t)
            0:       return "alu ops";
            1:       return "lui / auipc";
            2:       return "branches";
            3:       return "jal / jalr";
            4:       return "illegal opcodes";
            default: return "mixed";
        endcase
    endfunction

    // random word shaped into one instruction class
    // 0 alu, 1 upper imm, 2 branch, 3 jump, 4 illegal, 5 any of them
    function automatic word_t random_instr(input int cls);
        word_t      r;
        int         pick;
        logic [6:0] op;
        r    = $random(seed);
        pick = cls;
        if (cls == 5) begin
            pick = ($random(seed) & 32'h7fff_ffff) % 5;
        end
        case (pick)
            0: begin
                if (r[0]) begin
                    // funct7 either 0 or 0x20
                    r[31:25] = {1'b0, r[30], 5'b0};
                    r[6:0]   = OP_REG;
                end else begin
                    // shift immediates keep the same funct7 shape
                    if (r[13:12] == 2'b01) begin
                        r[31:25] = {1'b0, r[30], 5'b0};
                    end
                    r[6:0] = OP_IMM;
                end
            end
            1: r[6:0] = r[1] ? OP_LUI : OP_AUIPC;
            2: begin
                // same register on both sides now and then
                if (r[7]) begin
                    r[24:20] = r[19:15];
                end
                r[6:0] = OP_BRANCH;
            end
            3: begin
                if (!r[2]) begin
                    r[14:12] = 3'b000;
                end
                r[6:0] = r[2] ? OP_JAL : OP_JALR;
            end
            default: begin
                case (r[8:7])
                    2'b00:   op = 7'b0000011;
                    2'b01:   op = 7'b0100011;
                    default: op = 7'($random(seed));
                endcase
                // a legal opcode by chance becomes system
                if (op inside {OP_REG, OP_IMM, OP_LUI, OP_AUIPC, OP_BRANCH, OP_JAL, OP_JALR}) begin
                    op = 7'b1110011;
                end
                r[6:0] = op;
            end
        endcase
        return r;
    endfunction

    // one accepted instruction, about one cycle in five idle before it
    task automatic issue(input int cls);
        @(posedge clk);
        #1;
        while (($random(seed) & 255) < 51) begin
            cmd_valid = 1'b0;
            cmd       = random_instr(cls);
            @(posedge clk);
            #1;
        end
        cmd_valid = 1'b1;
        cmd       = random_instr(cls);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("simulation timed out before all tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        seed      = 32'h24c86781;
        rst       = 1'b1;
        cmd       = '0;
        cmd_valid = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = errors;
            for (int n = 0; n < INSTRS_PER_TEST; n++) begin
                issue(t);
            end
            // last one retires here
            @(posedge clk);
            #1;
            cmd_valid = 1'b0;
            $display("test %0d, %s: %0d instructions, %0d errors",
                     t, test_name(t), INSTRS_PER_TEST, errors - errs_before);
        end
        @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if ((errors == 0) && (checks > 0)) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/cpu_checker.sv ====
// ------------------
// rv32i reference checker
// isa model of pc and registers,
// compares the core's outputs each cycle
// ------------------
`timescale 1ns/100ps
`default_nettype none

module cpu_checker import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t cmd,
    input  logic  cmd_valid,
    input  word_t pc,
    input  word_t dnpc,
    input  wb_t   wb,
    input  logic  illegal,
    output int    errors,
    output int    checks
);

    // architectural state of the model
    word_t mpc;
    word_t mregs [32];
    // prediction for the word on cmd
    logic  exp_wen;
    word_t exp_data;
    word_t exp_npc;
    logic  exp_bad;
    logic  exp_valid;

    // integer op by funct3 with alt selecting sub / sra
    function automatic word_t int_op(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            // sra as a logical shift with the vacated top bits set from the sign
            3'd5:    return alt ? (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0)
                                : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // expected effects of cmd against the model state
    task automatic predict();
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_b;
        word_t      imm_j;
        logic       take;
        f3    = cmd[14:12];
        f7    = cmd[31:25];
        a     = mregs[cmd[19:15]];
        b     = mregs[cmd[24:20]];
        imm_i = {{20{cmd[31]}}, cmd[31:20]};
        imm_b = {{20{cmd[31]}}, cmd[7], cmd[30:25], cmd[11:8], 1'b0};
        imm_j = {{12{cmd[31]}}, cmd[19:12], cmd[20], cmd[30:21], 1'b0};
        take     = 1'b0;
        exp_wen  = 1'b0;
        exp_bad  = 1'b0;
        exp_data = '0;
        exp_npc  = mpc + 32'd4;
        case (cmd[6:0])
            OP_REG: begin
                exp_bad  = !((f7 == 7'h00) ||
                             ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
                exp_data = int_op(f3, f7[5], a, b);
            end
            OP_IMM: begin
                // slli needs funct7 zero and srli / srai zero or 0x20
                exp_bad  = ((f3 == 3'd1) && (f7 != 7'h00)) ||
                           ((f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20));
                exp_data = int_op(f3, (f3 == 3'd5) && f7[5], a, imm_i);
            end
            OP_LUI:   exp_data = {cmd[31:12], 12'h000};
            OP_AUIPC: exp_data = mpc + {cmd[31:12], 12'h000};
            OP_BRANCH: begin
                case (f3)
                    3'd0:    take = (a == b);
                    3'd1:    take = (a != b);
                    3'd4:    take = ($signed(a) < $signed(b));
                    3'd5:    take = ($signed(a) >= $signed(b));
                    3'd6:    take = (a < b);
                    3'd7:    take = (a >= b);
                    default: exp_bad = 1'b1;
                endcase
                if (take) begin
                    exp_npc = mpc + imm_b;
                end
            end
            OP_JAL: begin
                exp_data = mpc + 32'd4;
                exp_npc  = mpc + imm_j;
            end
            OP_JALR: begin
                exp_bad  = (f3 != 3'd0);
                exp_data = mpc + 32'd4;
                if (!exp_bad) begin
                    exp_npc = (a + imm_i) & ~32'h1;
                end
            end
            default: exp_bad = 1'b1;
        endcase
        // only these formats write a register
        exp_wen = !exp_bad && (cmd[6:0] != OP_BRANCH);
    endtask

    task automatic check_value(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns: %s is %h, expected %h (cmd %h, pc %h)",
                     $time, what, got, exp, cmd, mpc);
        end
    endtask

    // inputs and combinational outputs have settled by mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            errors = 0;
            checks = 0;
            mpc    = RESET_PC;
            for (int i = 0; i < 32; i++) begin
                mregs[i] = '0;
            end
        end else begin
            predict();
            exp_valid = cmd_valid && exp_wen && (cmd[11:7] != 5'd0);
            check_value("pc", pc, mpc);
            check_value("dnpc", dnpc, exp_npc);
            check_value("illegal", {31'b0, illegal}, {31'b0, cmd_valid && exp_bad});
            check_value("wb.valid", {31'b0, wb.valid}, {31'b0, exp_valid});
            if (exp_valid) begin
                check_value("wb.rd", {27'b0, wb.rd}, {27'b0, cmd[11:7]});
                check_value("wb.data", wb.data, exp_data);
            end
            // core retires this on the coming rising edge
            if (cmd_valid) begin
                if (exp_valid) begin
                    mregs[cmd[11:7]] = exp_data;
                end
                mpc = exp_npc;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpu.sv ====
// ------------------
// rv32i single-cycle core
// decode, register read, execute and
// writeback in the accepting cycle
// ------------------
`timescale 1ns/100ps
`default_nettype none

module cpu import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t cmd,
    input  logic  cmd_valid,
    output word_t pc,
    output word_t dnpc,
    output wb_t   wb,
    output logic  illegal
);

    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    ctrl_t     ctrl;
    logic      dec_illegal;
    word_t     imm;
    word_t     src1;
    word_t     src2;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    logic      eq;
    logic      lt;
    logic      ltu;

    // u-type has no rs1 field so x0 is read instead
    assign rs1 = (ctrl.imm_fmt == IMM_U) ? '0 : cmd[19:15];
    assign rs2 = cmd[24:20];
    assign rd  = cmd[11:7];

    control_unit u_control_unit (
        .opcode    (cmd[6:0]),
        .funct3    (cmd[14:12]),
        .funct7_b5 (cmd[30]),
        .ctrl      (ctrl),
        .illegal   (dec_illegal)
    );

    imm_decode u_imm_decode (.cmd(cmd), .fmt(ctrl.imm_fmt), .imm(imm));

    register_file #(.DEPTH(NUM_REGS)) u_register_file (
        .clk     (clk),
        .rst     (rst),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .waddr   (wb.rd),
        .wdata   (wb.data),
        .wen     (wb.valid),
        .rdata_a (src1),
        .rdata_b (src2)
    );

    // operand muxes
    assign alu_a = (ctrl.a_src == A_PC) ? pc : src1;

    always_comb begin
        case (ctrl.b_src)
            B_IMM:   alu_b = imm;
            B_FOUR:  alu_b = 32'd4;
            default: alu_b = src2;
        endcase
    end

    alu u_alu (
        .op (ctrl.alu_op), .a (alu_a), .b (alu_b),
        .result (alu_result), .eq (eq), .lt (lt), .ltu (ltu)
    );

    pc_unit u_pc_unit (
        .clk (clk), .rst (rst), .step (cmd_valid), .kind (ctrl.branch),
        .eq (eq), .lt (lt), .ltu (ltu), .imm (imm), .rs1_val (src1),
        .pc (pc), .dnpc (dnpc)
    );

    // record of the retiring write with x0 dropped
    assign wb = '{valid: cmd_valid && ctrl.reg_wen && (rd != '0),
                  rd:    rd,
                  data:  alu_result};

    assign illegal = cmd_valid && dec_illegal;

    // an idle cycle leaves the pc where it was
    a_idle_hold: assert property (@(posedge clk) disable iff (rst)
        !cmd_valid |=> $stable(pc));

    // decoder hands illegal encodings a no-write control
    a_illegal_no_write: assert property (@(posedge clk) disable iff (rst)
        illegal |-> !wb.valid);

endmodule

`default_nettype wire

// ==== logic/pc_unit.sv ====
// ------------------
// program counter
// branch resolution, next-pc select
// and the pc register
// ------------------
`timescale 1ns/100ps
`default_nettype none

module pc_unit import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    step,
    input  branch_e kind,
    input  logic    eq,
    input  logic    lt,
    input  logic    ltu,
    input  word_t   imm,
    input  word_t   rs1_val,
    output word_t   pc,
    output word_t   dnpc
);

    logic  taken;
    word_t seq_pc;
    word_t rel_pc;
    word_t jalr_sum;

    // own adders, the alu is busy with the link value
    assign seq_pc   = pc + 32'd4;
    assign rel_pc   = pc + imm;
    assign jalr_sum = rs1_val + imm;

    always_comb begin
        case (kind)
            BR_EQ:   taken = eq;
            BR_NE:   taken = !eq;
            BR_LT:   taken = lt;
            BR_GE:   taken = !lt;
            BR_LTU:  taken = ltu;
            BR_GEU:  taken = !ltu;
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jalr clears bit 0 of the sum
    assign dnpc = (kind == BR_JALR) ? {jalr_sum[31:1], 1'b0} :
                  taken             ? rel_pc : seq_pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (step) begin
            pc <= dnpc;
        end
    end

    // word-aligned pc and offsets keep the next pc word-aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        (step && (pc[1:0] == 2'b00) && (imm[1:0] == 2'b00) &&
         ((kind != BR_JALR) || (rs1_val[1:0] == 2'b00)))
        |=> (pc[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
// ------------------
// integer alu
// ten rv32i operations plus compare flags
// from one shared subtractor
// ------------------
`timescale 1ns/100ps
`default_nettype none

module alu import rv_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    eq,
    output logic    lt,
    output logic    ltu
);

    // 33 bits so the borrow falls out at the top
    logic [32:0] diff;
    logic [4:0]  shamt;

    assign diff  = {1'b0, a} - {1'b0, b};
    assign shamt = b[4:0];

    // flags always a vs b
    assign eq  = (diff[31:0] == '0);
    assign ltu = diff[32];
    // on differing signs a is less iff a is negative
    assign lt  = (a[31] != b[31]) ? a[31] : diff[31];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = diff[31:0];
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'b0, lt};
            ALU_SLTU: result = {31'b0, ltu};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
// ------------------
// integer register file
// two async read ports, one write port,
// x0 fixed at zero
// ------------------
`timescale 1ns/100ps
`default_nettype none

module register_file import rv_pkg::*; #(
    parameter int DEPTH = NUM_REGS
) (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t raddr_a,
    input  reg_addr_t raddr_b,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  logic      wen,
    output word_t     rdata_a,
    output word_t     rdata_b
);

    word_t regs [DEPTH];

    // cleared on reset; x0 and indices past depth never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0) && (waddr < DEPTH)) begin
            regs[waddr] <= wdata;
        end
    end

    // no bypass, single-cycle core reads before the write edge
    // x0 and unimplemented registers read zero
    assign rdata_a = ((raddr_a != '0) && (raddr_a < DEPTH)) ? regs[raddr_a] : '0;
    assign rdata_b = ((raddr_b != '0) && (raddr_b < DEPTH)) ? regs[raddr_b] : '0;

endmodule

`default_nettype wire

// ==== logic/imm_decode.sv ====
// ------------------
// immediate decoder
// gathers and sign-extends the immediate
// for the i, u, b and j formats
// ------------------
`timescale 1ns/100ps
`default_nettype none

module imm_decode import rv_pkg::*; (
    input  word_t    cmd,
    input  imm_fmt_e fmt,
    output word_t    imm
);

    // sign bit is always cmd[31]
    logic sign;

    assign sign = cmd[31];

    always_comb begin
        case (fmt)
            // 12 bits, addi / jalr / shifts
            IMM_I: imm = {{20{sign}}, cmd[31:20]};
            // upper 20 bits, low 12 zero
            IMM_U: imm = {cmd[31:12], 12'b0};
            // branch offset, bit 0 implied zero
            IMM_B: imm = {{19{sign}}, sign, cmd[7], cmd[30:25], cmd[11:8], 1'b0};
            // jal offset, 21 bits
            IMM_J: imm = {{11{sign}}, sign, cmd[19:12], cmd[20], cmd[30:21], 1'b0};
            // r-type and illegal
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/control_unit.sv ====
// ------------------
// instruction decoder
// opcode and funct bits to the control record,
// flags encodings the core does not retire
// ------------------
`timescale 1ns/100ps
`default_nettype none

module control_unit import rv_pkg::*; (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic       funct7_b5,
    output ctrl_t      ctrl,
    output logic       illegal
);

    ctrl_t dec;
    logic  bad;
    logic  alt;

    // funct3 to alu op, alt picks sub / sra
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt_op);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = alt_op ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt_op ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // for op-imm bit 30 is immediate, except on the right shifts
    assign alt = (opcode == OP_REG) ? funct7_b5 : (funct3 == F3_SR) && funct7_b5;

    always_comb begin
        dec = CTRL_NOP;
        bad = 1'b0;
        case (opcode)
            OP_REG: begin
                dec.alu_op  = alu_sel(funct3, alt);
                dec.reg_wen = 1'b1;
                // only add/sub and srl/sra have an alternate form
                bad = funct7_b5 && (funct3 != F3_ADD) && (funct3 != F3_SR);
            end
            OP_IMM: begin
                dec.alu_op  = alu_sel(funct3, alt);
                dec.b_src   = B_IMM;
                dec.imm_fmt = IMM_I;
                dec.reg_wen = 1'b1;
                // slli with bit 30 set
                bad = (funct3 == F3_SLL) && funct7_b5;
            end
            OP_LUI: begin
                // rs1 reads x0 for u-type, so add gives the immediate
                dec.b_src   = B_IMM;
                dec.imm_fmt = IMM_U;
                dec.reg_wen = 1'b1;
            end
            OP_AUIPC: begin
                dec.a_src   = A_PC;
                dec.b_src   = B_IMM;
                dec.imm_fmt = IMM_U;
                dec.reg_wen = 1'b1;
            end
            OP_BRANCH: begin
                // compare rs1 with rs2 through the subtractor
                dec.alu_op  = ALU_SUB;
                dec.imm_fmt = IMM_B;
                case (funct3)
                    3'b000:  dec.branch = BR_EQ;
                    3'b001:  dec.branch = BR_NE;
                    3'b100:  dec.branch = BR_LT;
                    3'b101:  dec.branch = BR_GE;
                    3'b110:  dec.branch = BR_LTU;
                    3'b111:  dec.branch = BR_GEU;
                    default: bad = 1'b1;
                endcase
            end
            OP_JAL: begin
                // link value pc + 4 from the alu
                dec.a_src   = A_PC;
                dec.b_src   = B_FOUR;
                dec.imm_fmt = IMM_J;
                dec.branch  = BR_JAL;
                dec.reg_wen = 1'b1;
            end
            OP_JALR: begin
                dec.a_src   = A_PC;
                dec.b_src   = B_FOUR;
                dec.imm_fmt = IMM_I;
                dec.branch  = BR_JALR;
                dec.reg_wen = 1'b1;
                bad = (funct3 != 3'b000);
            end
            // loads, stores, fence, system and the rest
            default: bad = 1'b1;
        endcase
    end

    assign ctrl    = bad ? CTRL_NOP : dec;
    assign illegal = bad;

endmodule

`default_nettype wire

// ==== logic/rv_pkg.sv ====
// ------------------
// rv32i core package
// widths, operation selectors, control and
// retirement records, opcode constants
// ------------------
`default_nettype none

package rv_pkg;

    // data and address words
    typedef logic [31:0] word_t;
    // register index, five bits even for rv32e
    typedef logic [4:0]  reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000;
    localparam int    NUM_REGS = 32;

    // major opcodes that retire
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // funct3 of the integer ops, shared by reg and imm forms
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic { A_RS1, A_PC } a_src_e;

    typedef enum logic [1:0] { B_RS2, B_IMM, B_FOUR } b_src_e;

    typedef enum logic [2:0] { IMM_NONE, IMM_I, IMM_U, IMM_B, IMM_J } imm_fmt_e;

    // how the next pc is formed
    typedef enum logic [3:0] {
        BR_SEQ, BR_EQ, BR_NE, BR_LT, BR_GE,
        BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } branch_e;

    typedef struct packed {
        alu_op_e  alu_op;
        a_src_e   a_src;
        b_src_e   b_src;
        imm_fmt_e imm_fmt;
        branch_e  branch;
        logic     reg_wen;
    } ctrl_t;

    // sequential, no write; used for illegal encodings
    localparam ctrl_t CTRL_NOP = '{ALU_ADD, A_RS1, B_RS2, IMM_NONE, BR_SEQ, 1'b0};

    // retirement record
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire
